// File: bench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [15:0] lfsr_state;
logic [31:0] model_regs [32];

// ----------------------------------------------------------------------
// random source and instruction generator
// ----------------------------------------------------------------------
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
        bits       = {bits[30:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
    end
    return bits;
endfunction

function automatic cpu_pkg::instr_u gen_instr();
    cpu_pkg::instr_u ins;
    logic [3:0]      cls;
    logic [3:0]      sel;
    ins.r.op    = cpu_pkg::OP_RTYPE;
    ins.r.rs    = 5'(take_bits(3));    // registers 0 to 7 keep dependencies close
    ins.r.rt    = 5'(take_bits(3));
    ins.r.rd    = 5'(take_bits(3));
    ins.r.shamt = 5'(take_bits(5));
    ins.r.funct = 6'(take_bits(6));
    cls = 4'(take_bits(4));
    sel = 4'(take_bits(4));
    if (cls < 4'd6) begin
        case (sel % 11)
            0:       ins.r.funct = cpu_pkg::F_ADDU;
            1:       ins.r.funct = cpu_pkg::F_SUBU;
            2:       ins.r.funct = cpu_pkg::F_AND;
            3:       ins.r.funct = cpu_pkg::F_OR;
            4:       ins.r.funct = cpu_pkg::F_XOR;
            5:       ins.r.funct = cpu_pkg::F_NOR;
            6:       ins.r.funct = cpu_pkg::F_SLT;
            7:       ins.r.funct = cpu_pkg::F_SLTU;
            8:       ins.r.funct = cpu_pkg::F_SLL;
            9:       ins.r.funct = cpu_pkg::F_SRL;
            default: ins.r.funct = cpu_pkg::F_SRA;
        endcase
    end else if (cls < 4'd15) begin
        ins.i.imm16 = 16'(take_bits(16));
        if (cls < 4'd10) begin
            case (sel % 6)
                0:       ins.i.op = cpu_pkg::OP_ADDIU;
                1:       ins.i.op = cpu_pkg::OP_SLTI;
                2:       ins.i.op = cpu_pkg::OP_ANDI;
                3:       ins.i.op = cpu_pkg::OP_ORI;
                4:       ins.i.op = cpu_pkg::OP_XORI;
                default: ins.i.op = cpu_pkg::OP_LUI;
            endcase
        end else if (cls < 4'd13) begin
            case (sel % 6)
                0:       ins.i.op = cpu_pkg::OP_LB;
                1:       ins.i.op = cpu_pkg::OP_LH;
                2:       ins.i.op = cpu_pkg::OP_LW;
                3:       ins.i.op = cpu_pkg::OP_SB;
                4:       ins.i.op = cpu_pkg::OP_SH;
                default: ins.i.op = cpu_pkg::OP_SW;
            endcase
        end else begin
            ins.i.op = sel[0] ? cpu_pkg::OP_BNE : cpu_pkg::OP_BEQ;
        end
    end else if (sel[0]) begin
        ins.j.op       = cpu_pkg::OP_J;
        ins.j.target26 = 26'(take_bits(26));
    end else begin
        ins.r.op = 6'(take_bits(6));    // mostly encodings the core does not support
    end
    return ins;
endfunction

// ----------------------------------------------------------------------
// architectural model, one instruction in program order
// ----------------------------------------------------------------------
function automatic cpu_pkg::ex_out_t model_exec(input cpu_pkg::instr_u ins,
                                                input logic [31:0] pc);
    cpu_pkg::ex_out_t e;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      sx;
    logic [31:0]      zx;
    logic [31:0]      pc4;
    logic [4:0]       dst;
    logic             wr;
    e   = '0;
    a   = model_regs[ins.r.rs];
    b   = model_regs[ins.r.rt];
    sx  = {{16{ins.i.imm16[15]}}, ins.i.imm16};
    zx  = {16'h0000, ins.i.imm16};
    pc4 = pc + 32'd4;
    dst = ins.i.rt;
    wr  = 1'b1;
    case (ins.r.op)
        cpu_pkg::OP_RTYPE: begin
            dst = ins.r.rd;
            case (ins.r.funct)
                cpu_pkg::F_ADDU: e.result = a + b;
                cpu_pkg::F_SUBU: e.result = a - b;
                cpu_pkg::F_AND:  e.result = a & b;
                cpu_pkg::F_OR:   e.result = a | b;
                cpu_pkg::F_XOR:  e.result = a ^ b;
                cpu_pkg::F_NOR:  e.result = ~(a | b);
                cpu_pkg::F_SLT:  e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                cpu_pkg::F_SLTU: e.result = (a < b) ? 32'd1 : 32'd0;
                cpu_pkg::F_SLL:  e.result = b << ins.r.shamt;
                cpu_pkg::F_SRL:  e.result = b >> ins.r.shamt;
                cpu_pkg::F_SRA:  e.result = $signed(b) >>> ins.r.shamt;
                default:         wr = 1'b0;
            endcase
        end
        cpu_pkg::OP_ADDIU: e.result = a + sx;
        cpu_pkg::OP_SLTI:  e.result = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
        cpu_pkg::OP_ANDI:  e.result = a & zx;
        cpu_pkg::OP_ORI:   e.result = a | zx;
        cpu_pkg::OP_XORI:  e.result = a ^ zx;
        cpu_pkg::OP_LUI:   e.result = {ins.i.imm16, 16'h0000};
        cpu_pkg::OP_LB, cpu_pkg::OP_LH, cpu_pkg::OP_LW,
        cpu_pkg::OP_SB, cpu_pkg::OP_SH, cpu_pkg::OP_SW: begin
            wr = 1'b0;
            e.mem_req.valid = 1'b1;
            e.mem_req.write = (ins.i.op == cpu_pkg::OP_SB) || (ins.i.op == cpu_pkg::OP_SH) ||
                              (ins.i.op == cpu_pkg::OP_SW);
            if (ins.i.op == cpu_pkg::OP_LB || ins.i.op == cpu_pkg::OP_SB) begin
                e.mem_req.size = cpu_pkg::MEM_BYTE;
            end else if (ins.i.op == cpu_pkg::OP_LH || ins.i.op == cpu_pkg::OP_SH) begin
                e.mem_req.size = cpu_pkg::MEM_HALF;
            end else begin
                e.mem_req.size = cpu_pkg::MEM_WORD;
            end
            e.mem_req.addr  = a + sx;
            e.mem_req.wdata = e.mem_req.write ? b : 32'd0;
        end
        cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: begin
            wr = 1'b0;
            e.redirect.valid  = (ins.i.op == cpu_pkg::OP_BEQ) ? (a == b) : (a != b);
            e.redirect.target = e.redirect.valid ? pc4 + (sx << 2) : 32'd0;
        end
        cpu_pkg::OP_J: begin
            wr = 1'b0;
            e.redirect.valid  = 1'b1;
            e.redirect.target = {pc4[31:28], ins.j.target26, 2'b00};
        end
        default: wr = 1'b0;
    endcase
    if (wr) begin
        e.result_wr = 1'b1;
        e.result_rd = dst;
        if (dst != 5'd0) begin
            model_regs[dst] = e.result;    // register 0 drops every write
        end
    end
    return e;
endfunction

`endif

// File: bench/tb_exec_core.sv
`default_nettype none

module tb_exec_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NBITS       = cpu_pkg::NBITS_DEF;
    localparam int N_INSTR     = 3000;
    localparam int MAX_CYCLES  = 8000;
    localparam int DRAIN_LIMIT = 4;
    localparam int SEED        = 46837;
    localparam int DRIVE_DELAY = 5;

    logic             i_clk;
    logic             i_rst;
    logic             i_valid;
    cpu_pkg::instr_u  i_instr;
    logic [NBITS-1:0] i_pc;
    logic             o_valid;
    cpu_pkg::ex_out_t o_ex;

    logic             exp_valid_q [$];
    cpu_pkg::ex_out_t exp_ex_q [$];

    `include "tb_ref_model.svh"

    exec_core_top #(.NBITS(NBITS)) dut0 (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (i_valid),
        .i_instr (i_instr),
        .i_pc    (i_pc),
        .o_valid (o_valid),
        .o_ex    (o_ex)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // ----------------------------------------------------------------------
    // checking
    // ----------------------------------------------------------------------
    task automatic stop_with_failure();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [NBITS-1:0] got,
                               input logic [NBITS-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_outputs();
        logic             exp_v;
        cpu_pkg::ex_out_t exp_e;
        exp_v = exp_valid_q.pop_front();
        exp_e = exp_ex_q.pop_front();
        check_value("o_valid", o_valid, exp_v);
        check_value("result", o_ex.result, exp_e.result);
        check_value("result_rd", o_ex.result_rd, exp_e.result_rd);
        check_value("result_wr", o_ex.result_wr, exp_e.result_wr);
        check_value("mem_req.valid", o_ex.mem_req.valid, exp_e.mem_req.valid);
        check_value("mem_req.write", o_ex.mem_req.write, exp_e.mem_req.write);
        check_value("mem_req.size", o_ex.mem_req.size, exp_e.mem_req.size);
        check_value("mem_req.addr", o_ex.mem_req.addr, exp_e.mem_req.addr);
        check_value("mem_req.wdata", o_ex.mem_req.wdata, exp_e.mem_req.wdata);
        check_value("redirect.valid", o_ex.redirect.valid, exp_e.redirect.valid);
        check_value("redirect.target", o_ex.redirect.target, exp_e.redirect.target);
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    initial begin
        cpu_pkg::instr_u  ins;
        logic [NBITS-1:0] pc;
        logic             v;
        int               issued;
        int               cycles;
        int               drain;

        i_rst      = 1'b1;
        i_valid    = 1'b0;
        i_instr    = '0;
        i_pc       = '0;
        lfsr_state = 16'(SEED);
        issued     = 0;
        cycles     = 0;
        drain      = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int k = 0; k < 10; k++) begin
            @(posedge i_clk);
        end
        #DRIVE_DELAY;
        i_rst = 1'b0;
        exp_valid_q.push_back(1'b0);    // reset state, then the idle cycle at release
        exp_ex_q.push_back('0);
        exp_valid_q.push_back(1'b0);
        exp_ex_q.push_back('0);

        while (issued < N_INSTR) begin
            @(posedge i_clk);
            #DRIVE_DELAY;
            check_outputs();
            cycles++;
            if (cycles > MAX_CYCLES) begin
                $display("timeout, %0d of %0d instructions issued in %0d cycles",
                         issued, N_INSTR, cycles);
                stop_with_failure();
            end
            v       = (take_bits(5) < 26);    // about 80 percent of cycles carry a strobe
            ins     = gen_instr();
            pc      = take_bits(30) << 2;
            i_valid = v;
            i_instr = ins;    // idle cycles still present a word to the decoder
            i_pc    = pc;
            if (v) begin
                exp_valid_q.push_back(1'b1);
                exp_ex_q.push_back(model_exec(ins, pc));
                issued++;
            end else begin
                exp_valid_q.push_back(1'b0);
                exp_ex_q.push_back('0);
            end
        end

        while (exp_valid_q.size() > 0) begin
            @(posedge i_clk);
            #DRIVE_DELAY;
            check_outputs();
            i_valid = 1'b0;
            drain++;
            if (drain > DRAIN_LIMIT) begin
                $display("timeout, results still pending after the last instruction");
                stop_with_failure();
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+bench
verilog/cpu_pkg.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/agu.sv
verilog/instr_decoder.sv
verilog/id_ex_reg.sv
verilog/ex_stage.sv
verilog/exec_core_top.sv
bench/tb_exec_core.sv

// File: verilog/agu.sv
`default_nettype none

module agu #(
    parameter int NBITS = cpu_pkg::NBITS_DEF
) (
    input  wire cpu_pkg::agu_op_e i_opcode,
    input  wire  [NBITS-1:0]      i_pc,
    input  wire  [NBITS-1:0]      i_base,
    input  wire  [NBITS-1:0]      i_rt_val,
    input  wire  [25:0]           i_addr_offset,
    output logic [NBITS-1:0]      o_addr,
    output logic                  o_redirect_valid,
    output logic [NBITS-1:0]      o_target
);

    logic [NBITS-1:0] off_sext;
    logic [NBITS-1:0] pc_next;

    assign off_sext = {{(NBITS-16){i_addr_offset[15]}}, i_addr_offset[15:0]};
    assign pc_next  = i_pc + NBITS'(4);
    assign o_addr   = i_base + off_sext;

    always_comb begin
        o_target         = pc_next + (off_sext << 2);
        o_redirect_valid = 1'b0;
        case (i_opcode)
            cpu_pkg::AGU_BEQ: o_redirect_valid = (i_base == i_rt_val);
            cpu_pkg::AGU_BNE: o_redirect_valid = (i_base != i_rt_val);
            cpu_pkg::AGU_JUMP: begin
                o_redirect_valid = 1'b1;
                o_target         = {pc_next[NBITS-1:NBITS-4], i_addr_offset, 2'b00};
            end
            default: ;    // a memory access never redirects
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`default_nettype none

module alu #(
    parameter int NBITS = cpu_pkg::NBITS_DEF
) (
    input  wire cpu_pkg::alu_op_e i_opcode,
    input  wire  [NBITS-1:0]      i_src_a,
    input  wire  [NBITS-1:0]      i_src_b,
    input  wire  [4:0]            i_shamt,
    output logic [NBITS-1:0]      o_result
);

    logic signed_lt;
    logic unsigned_lt;

    assign signed_lt   = $signed(i_src_a) < $signed(i_src_b);
    assign unsigned_lt = i_src_a < i_src_b;

    // shifts act on src_b, the rt operand of the R-type shift forms
    always_comb begin
        case (i_opcode)
            cpu_pkg::ALU_ADD:  o_result = i_src_a + i_src_b;
            cpu_pkg::ALU_SUB:  o_result = i_src_a - i_src_b;
            cpu_pkg::ALU_AND:  o_result = i_src_a & i_src_b;
            cpu_pkg::ALU_OR:   o_result = i_src_a | i_src_b;
            cpu_pkg::ALU_XOR:  o_result = i_src_a ^ i_src_b;
            cpu_pkg::ALU_NOR:  o_result = ~(i_src_a | i_src_b);
            cpu_pkg::ALU_SLT:  o_result = {{(NBITS-1){1'b0}}, signed_lt};
            cpu_pkg::ALU_SLTU: o_result = {{(NBITS-1){1'b0}}, unsigned_lt};
            cpu_pkg::ALU_SLL:  o_result = i_src_b << i_shamt;
            cpu_pkg::ALU_SRL:  o_result = i_src_b >> i_shamt;
            cpu_pkg::ALU_SRA:  o_result = $signed(i_src_b) >>> i_shamt;
            cpu_pkg::ALU_LUI:  o_result = {i_src_b[15:0], 16'h0000};
            default:           o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int NBITS_DEF = 32;

    // ----------------------------------------------------------------------
    // instruction formats
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target26;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LB    = 6'h20;
    localparam logic [5:0] OP_LH    = 6'h21;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SB    = 6'h28;
    localparam logic [5:0] OP_SH    = 6'h29;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] F_SLL  = 6'h00;
    localparam logic [5:0] F_SRL  = 6'h02;
    localparam logic [5:0] F_SRA  = 6'h03;
    localparam logic [5:0] F_ADDU = 6'h21;
    localparam logic [5:0] F_SUBU = 6'h23;
    localparam logic [5:0] F_AND  = 6'h24;
    localparam logic [5:0] F_OR   = 6'h25;
    localparam logic [5:0] F_XOR  = 6'h26;
    localparam logic [5:0] F_NOR  = 6'h27;
    localparam logic [5:0] F_SLT  = 6'h2a;
    localparam logic [5:0] F_SLTU = 6'h2b;

    // ----------------------------------------------------------------------
    // control codes and stage bundles
    // ----------------------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {AGU_MEM, AGU_BEQ, AGU_BNE, AGU_JUMP} agu_op_e;

    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

    typedef struct packed {
        logic [NBITS_DEF-1:0] pc;
        logic [4:0]           rd;
        logic [4:0]           rt;
        logic [25:0]          addr_offset;
        logic                 flg_mem_op;
        logic                 flg_mem_type;    // set for a store
        mem_size_e            flg_mem_size;
        logic                 flg_unsign;
        logic                 alu_enable;
        logic                 alu_dst;         // 1 writes rd, 0 writes rt
        alu_op_e              alu_opcode;
        logic                 agu_enable;
        agu_op_e              agu_opcode;
        logic                 flg_branch;
        logic                 flg_jump;
        logic [NBITS_DEF-1:0] alu_src_a;
        logic [NBITS_DEF-1:0] alu_src_b;
        logic [NBITS_DEF-1:0] agu_src_addr;    // rt value, store data and compare operand
        logic                 wr_en;
    } id_ex_t;

    typedef struct packed {
        logic                 valid;
        logic [4:0]           rnum;
        logic [NBITS_DEF-1:0] data;
    } fwd_t;

    typedef struct packed {
        logic                 valid;
        logic                 write;
        mem_size_e            size;
        logic [NBITS_DEF-1:0] addr;
        logic [NBITS_DEF-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                 valid;
        logic [NBITS_DEF-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic [NBITS_DEF-1:0] result;
        logic [4:0]           result_rd;
        logic                 result_wr;
        mem_req_t             mem_req;
        redirect_t            redirect;
    } ex_out_t;

endpackage

`default_nettype wire

// File: verilog/ex_stage.sv
`default_nettype none

module ex_stage #(
    parameter int NBITS = cpu_pkg::NBITS_DEF
) (
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire cpu_pkg::id_ex_t i_id_ex,
    input  wire                  i_valid,
    output cpu_pkg::fwd_t        o_fwd,
    output cpu_pkg::fwd_t        o_wb,
    output cpu_pkg::ex_out_t     o_ex,
    output logic                 o_valid
);

    logic [NBITS-1:0] alu_res;
    logic [NBITS-1:0] agu_addr;
    logic [NBITS-1:0] agu_target;
    logic             agu_taken;
    logic             wr_now;
    logic [4:0]       wb_rnum;
    cpu_pkg::ex_out_t ex_next;

    alu #(.NBITS(NBITS)) u_alu (
        .i_opcode (i_id_ex.alu_opcode),
        .i_src_a  (i_id_ex.alu_src_a),
        .i_src_b  (i_id_ex.alu_src_b),
        .i_shamt  (i_id_ex.addr_offset[10:6]),    // shamt field of the R format
        .o_result (alu_res)
    );

    agu #(.NBITS(NBITS)) u_agu (
        .i_opcode         (i_id_ex.agu_opcode),
        .i_pc             (i_id_ex.pc),
        .i_base           (i_id_ex.alu_src_a),
        .i_rt_val         (i_id_ex.agu_src_addr),
        .i_addr_offset    (i_id_ex.addr_offset),
        .o_addr           (agu_addr),
        .o_redirect_valid (agu_taken),
        .o_target         (agu_target)
    );

    // ----------------------------------------------------------------------
    // forward and write-back land before the next decode reads
    // ----------------------------------------------------------------------
    assign wr_now  = i_valid && i_id_ex.wr_en;
    assign wb_rnum = i_id_ex.alu_dst ? i_id_ex.rd : i_id_ex.rt;

    assign o_fwd = '{valid: wr_now, rnum: wb_rnum, data: alu_res};
    assign o_wb  = '{valid: wr_now, rnum: wb_rnum, data: alu_res};

    always_comb begin
        ex_next = '0;
        if (i_valid) begin
            ex_next.result    = i_id_ex.alu_enable ? alu_res : '0;
            ex_next.result_rd = wr_now ? wb_rnum : 5'd0;
            ex_next.result_wr = wr_now;
            if (i_id_ex.agu_enable && i_id_ex.flg_mem_op) begin
                ex_next.mem_req.valid = 1'b1;
                ex_next.mem_req.write = i_id_ex.flg_mem_type;
                ex_next.mem_req.size  = i_id_ex.flg_mem_size;
                ex_next.mem_req.addr  = agu_addr;
                ex_next.mem_req.wdata = i_id_ex.flg_mem_type ? i_id_ex.agu_src_addr : '0;
            end
            if (i_id_ex.agu_enable && (i_id_ex.flg_branch || i_id_ex.flg_jump) && agu_taken) begin
                ex_next.redirect.valid  = 1'b1;
                ex_next.redirect.target = agu_target;
            end
        end
    end

    // EX/WB register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ex    <= '0;
            o_valid <= 1'b0;
        end else begin
            o_ex    <= ex_next;
            o_valid <= i_valid;
        end
    end

    a_mem_xor_redirect: assert property (
        @(posedge i_clk) disable iff (i_rst)
        !(o_ex.mem_req.valid && o_ex.redirect.valid)
    );

endmodule

`default_nettype wire

// File: verilog/exec_core_top.sv
`default_nettype none

module exec_core_top #(
    parameter int NBITS = cpu_pkg::NBITS_DEF
) (
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_valid,
    input  wire cpu_pkg::instr_u i_instr,
    input  wire  [NBITS-1:0]     i_pc,
    output logic                 o_valid,
    output cpu_pkg::ex_out_t     o_ex
);

    logic [4:0]       rs_addr;
    logic [4:0]       rt_addr;
    logic [NBITS-1:0] rs_data;
    logic [NBITS-1:0] rt_data;
    cpu_pkg::fwd_t    ex_fwd;
    cpu_pkg::fwd_t    ex_wb;
    cpu_pkg::id_ex_t  dec_id_ex;
    cpu_pkg::id_ex_t  ex_id_ex;
    logic             dec_valid;
    logic             ex_valid;

    reg_file #(.NBITS(NBITS)) u_reg_file (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rs_addr (rs_addr),
        .i_rt_addr (rt_addr),
        .i_wb      (ex_wb),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    instr_decoder #(.NBITS(NBITS)) u_decoder (
        .i_valid   (i_valid),
        .i_instr   (i_instr),
        .i_pc      (i_pc),
        .i_rs_data (rs_data),
        .i_rt_data (rt_data),
        .i_fwd     (ex_fwd),
        .o_rs_addr (rs_addr),
        .o_rt_addr (rt_addr),
        .o_id_ex   (dec_id_ex),
        .o_valid   (dec_valid)
    );

    id_ex_reg #(.NBITS(NBITS)) u_id_ex_reg (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_id_ex (dec_id_ex),
        .i_valid (dec_valid),
        .o_id_ex (ex_id_ex),
        .o_valid (ex_valid)
    );

    ex_stage #(.NBITS(NBITS)) u_ex_stage (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_id_ex (ex_id_ex),
        .i_valid (ex_valid),
        .o_fwd   (ex_fwd),
        .o_wb    (ex_wb),
        .o_ex    (o_ex),
        .o_valid (o_valid)
    );

    // stage bundles are built at the package width
    a_width: assert property (@(posedge i_clk) NBITS == cpu_pkg::NBITS_DEF);

endmodule

`default_nettype wire

// File: verilog/id_ex_reg.sv
`default_nettype none

module id_ex_reg #(
    parameter int NBITS = cpu_pkg::NBITS_DEF
) (
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire cpu_pkg::id_ex_t i_id_ex,
    input  wire                  i_valid,
    output cpu_pkg::id_ex_t      o_id_ex,
    output logic                 o_valid
);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_id_ex <= '0;    // a cleared bundle has no enables and acts as a bubble
            o_valid <= 1'b0;
        end else begin
            o_id_ex <= i_id_ex;
            o_valid <= i_valid;
        end
    end

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
`default_nettype none

module instr_decoder #(
    parameter int NBITS = cpu_pkg::NBITS_DEF
) (
    input  wire                  i_valid,
    input  wire cpu_pkg::instr_u i_instr,
    input  wire  [NBITS-1:0]     i_pc,
    input  wire  [NBITS-1:0]     i_rs_data,
    input  wire  [NBITS-1:0]     i_rt_data,
    input  wire cpu_pkg::fwd_t   i_fwd,
    output logic [4:0]           o_rs_addr,
    output logic [4:0]           o_rt_addr,
    output cpu_pkg::id_ex_t      o_id_ex,
    output logic                 o_valid
);

    logic [NBITS-1:0] rs_val;
    logic [NBITS-1:0] rt_val;
    logic [NBITS-1:0] imm_sext;
    logic [NBITS-1:0] imm_zext;
    logic             fwd_hit;

    assign o_rs_addr = i_instr.r.rs;
    assign o_rt_addr = i_instr.r.rt;
    assign o_valid   = i_valid;

    // ----------------------------------------------------------------------
    // operand read with forwarding from EX
    // ----------------------------------------------------------------------
    assign fwd_hit = i_fwd.valid && i_fwd.rnum != 5'd0;
    assign rs_val  = (fwd_hit && i_fwd.rnum == i_instr.r.rs) ? i_fwd.data : i_rs_data;
    assign rt_val  = (fwd_hit && i_fwd.rnum == i_instr.r.rt) ? i_fwd.data : i_rt_data;

    assign imm_sext = {{(NBITS-16){i_instr.i.imm16[15]}}, i_instr.i.imm16};
    assign imm_zext = {{(NBITS-16){1'b0}}, i_instr.i.imm16};

    always_comb begin
        o_id_ex              = '0;    // anything not matched below stays a no-op
        o_id_ex.pc           = i_pc;
        o_id_ex.rd           = i_instr.r.rd;
        o_id_ex.rt           = i_instr.i.rt;
        o_id_ex.addr_offset  = i_instr.j.target26;
        o_id_ex.alu_src_a    = rs_val;
        o_id_ex.alu_src_b    = rt_val;
        o_id_ex.agu_src_addr = rt_val;
        case (i_instr.r.op)
            cpu_pkg::OP_RTYPE: begin
                o_id_ex.alu_enable = 1'b1;
                o_id_ex.alu_dst    = 1'b1;
                o_id_ex.flg_unsign = (i_instr.r.funct == cpu_pkg::F_SLTU);
                case (i_instr.r.funct)
                    cpu_pkg::F_ADDU: o_id_ex.alu_opcode = cpu_pkg::ALU_ADD;
                    cpu_pkg::F_SUBU: o_id_ex.alu_opcode = cpu_pkg::ALU_SUB;
                    cpu_pkg::F_AND:  o_id_ex.alu_opcode = cpu_pkg::ALU_AND;
                    cpu_pkg::F_OR:   o_id_ex.alu_opcode = cpu_pkg::ALU_OR;
                    cpu_pkg::F_XOR:  o_id_ex.alu_opcode = cpu_pkg::ALU_XOR;
                    cpu_pkg::F_NOR:  o_id_ex.alu_opcode = cpu_pkg::ALU_NOR;
                    cpu_pkg::F_SLT:  o_id_ex.alu_opcode = cpu_pkg::ALU_SLT;
                    cpu_pkg::F_SLTU: o_id_ex.alu_opcode = cpu_pkg::ALU_SLTU;
                    cpu_pkg::F_SLL:  o_id_ex.alu_opcode = cpu_pkg::ALU_SLL;
                    cpu_pkg::F_SRL:  o_id_ex.alu_opcode = cpu_pkg::ALU_SRL;
                    cpu_pkg::F_SRA:  o_id_ex.alu_opcode = cpu_pkg::ALU_SRA;
                    default:         o_id_ex.alu_enable = 1'b0;
                endcase
            end
            cpu_pkg::OP_ADDIU, cpu_pkg::OP_SLTI, cpu_pkg::OP_ANDI,
            cpu_pkg::OP_ORI, cpu_pkg::OP_XORI, cpu_pkg::OP_LUI: begin
                o_id_ex.alu_enable = 1'b1;
                o_id_ex.flg_unsign = i_instr.i.op[2];    // logic ops and LUI zero-extend
                o_id_ex.alu_src_b  = i_instr.i.op[2] ? imm_zext : imm_sext;
                case (i_instr.i.op)
                    cpu_pkg::OP_ADDIU: o_id_ex.alu_opcode = cpu_pkg::ALU_ADD;
                    cpu_pkg::OP_SLTI:  o_id_ex.alu_opcode = cpu_pkg::ALU_SLT;
                    cpu_pkg::OP_ANDI:  o_id_ex.alu_opcode = cpu_pkg::ALU_AND;
                    cpu_pkg::OP_ORI:   o_id_ex.alu_opcode = cpu_pkg::ALU_OR;
                    cpu_pkg::OP_XORI:  o_id_ex.alu_opcode = cpu_pkg::ALU_XOR;
                    default:           o_id_ex.alu_opcode = cpu_pkg::ALU_LUI;
                endcase
            end
            cpu_pkg::OP_LB, cpu_pkg::OP_LH, cpu_pkg::OP_LW,
            cpu_pkg::OP_SB, cpu_pkg::OP_SH, cpu_pkg::OP_SW: begin
                o_id_ex.agu_enable   = 1'b1;
                o_id_ex.agu_opcode   = cpu_pkg::AGU_MEM;
                o_id_ex.flg_mem_op   = 1'b1;
                o_id_ex.flg_mem_type = i_instr.i.op[3];    // stores sit at 0x28 and up
                o_id_ex.flg_mem_size = i_instr.i.op[1] ? cpu_pkg::MEM_WORD :
                                       i_instr.i.op[0] ? cpu_pkg::MEM_HALF : cpu_pkg::MEM_BYTE;
            end
            cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: begin
                o_id_ex.agu_enable = 1'b1;
                o_id_ex.flg_branch = 1'b1;
                o_id_ex.agu_opcode = i_instr.i.op[0] ? cpu_pkg::AGU_BNE : cpu_pkg::AGU_BEQ;
            end
            cpu_pkg::OP_J: begin
                o_id_ex.agu_enable = 1'b1;
                o_id_ex.flg_jump   = 1'b1;
                o_id_ex.agu_opcode = cpu_pkg::AGU_JUMP;
            end
            default: ;
        endcase
        o_id_ex.wr_en = o_id_ex.alu_enable;    // loads write nothing back
    end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`default_nettype none

module reg_file #(
    parameter int NBITS = cpu_pkg::NBITS_DEF
) (
    input  wire                i_clk,
    input  wire                i_rst,
    input  wire  [4:0]         i_rs_addr,
    input  wire  [4:0]         i_rt_addr,
    input  wire cpu_pkg::fwd_t i_wb,
    output logic [NBITS-1:0]   o_rs_data,
    output logic [NBITS-1:0]   o_rt_data
);

    logic [NBITS-1:0] regs [32];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.valid && i_wb.rnum != 5'd0) begin
            regs[i_wb.rnum] <= i_wb.data;
        end
    end

    // no write-through, the EX forward covers a read of the register being written
    assign o_rs_data = (i_rs_addr == 5'd0) ? '0 : regs[i_rs_addr];
    assign o_rt_data = (i_rt_addr == 5'd0) ? '0 : regs[i_rt_addr];

    a_r0_zero: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (i_wb.valid && i_wb.rnum == 5'd0) |=> regs[0] == '0
    );

endmodule

`default_nettype wire
